//--- rtl/serial_alu_macros.svh
// Serial ALU width macros
`ifndef SERIAL_ALU_MACROS_SVH
`define SERIAL_ALU_MACROS_SVH

// operand and result word width
`define SALU_WIDTH 32

// nibbles per word
`define SALU_NIBBLES 8

// width of the nibble index
`define SALU_IDX_W 3

// unloaded cycles from command capture to result request
// 1 take + 8 nibbles + 1 done + 1 result capture
`define SALU_MIN_LAT 11

`endif

//--- rtl/serial_alu_pkg.sv
// Serial ALU types
package serial_alu_pkg;

    // opcodes, code 7 is reserved as illegal
    typedef enum logic [2:0] {
        OP_ADD     = 3'd0,
        OP_SUB     = 3'd1,
        OP_AND     = 3'd2,
        OP_OR      = 3'd3,
        OP_XOR     = 3'd4,
        OP_SHL     = 3'd5,
        OP_SHR     = 3'd6,
        OP_ILLEGAL = 3'd7
    } alu_op_e;

    // execute stage states
    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_RUN  = 2'd1,
        SEQ_DONE = 2'd2
    } seq_state_e;

    // four-phase link states
    typedef enum logic [1:0] {
        LINK_IDLE      = 2'd0,
        LINK_REQ       = 2'd1,
        LINK_WAIT_DROP = 2'd2
    } link_state_e;

endpackage

//--- rtl/nibble_alu.sv
// Nibble ALU slice
`timescale 1ns/1ps

module nibble_alu (
    input  serial_alu_pkg::alu_op_e op,
    input  logic [3:0]              a,
    input  logic [3:0]              b,
    input  logic                    cin,
    output logic [3:0]              y,
    output logic                    cout
);

    logic [3:0] b_eff;
    logic [4:0] sum;

    // subtract is add of the inverted operand, cin supplies the +1
    assign b_eff = (op == serial_alu_pkg::OP_SUB) ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {4'b0000, cin};

    always_comb begin
        case (op)
            serial_alu_pkg::OP_ADD,
            serial_alu_pkg::OP_SUB: begin
                y    = sum[3:0];
                cout = sum[4];
            end
            serial_alu_pkg::OP_AND: begin
                y    = a & b;
                cout = 1'b0;
            end
            serial_alu_pkg::OP_OR: begin
                y    = a | b;
                cout = 1'b0;
            end
            serial_alu_pkg::OP_XOR: begin
                y    = a ^ b;
                cout = 1'b0;
            end
            serial_alu_pkg::OP_SHL: begin
                // bit from the nibble below comes in through cin
                y    = {a[2:0], cin};
                cout = a[3];
            end
            serial_alu_pkg::OP_SHR: begin
                // bit from the nibble above comes in through cin
                y    = {cin, a[3:1]};
                cout = a[0];
            end
            default: begin
                y    = 4'h0;
                cout = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/op_decode.sv
// Command decode stage
`timescale 1ns/1ps
`include "serial_alu_macros.svh"

module op_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cmd_req,
    input  logic [2:0]               cmd_op,
    input  logic [`SALU_WIDTH-1:0]   cmd_a,
    input  logic [`SALU_WIDTH-1:0]   cmd_b,
    output logic                     cmd_ack,
    output logic                     buf_valid,
    output serial_alu_pkg::alu_op_e  buf_op,
    output logic [`SALU_WIDTH-1:0]   buf_a,
    output logic [`SALU_WIDTH-1:0]   buf_b,
    output logic                     buf_reverse,
    output logic                     buf_carry_init,
    input  logic                     buf_take
);

    serial_alu_pkg::link_state_e link_state;
    serial_alu_pkg::alu_op_e     dec_op;
    logic                        capture;

    // raw code to opcode, anything unknown is illegal
    always_comb begin
        case (cmd_op)
            3'd0:    dec_op = serial_alu_pkg::OP_ADD;
            3'd1:    dec_op = serial_alu_pkg::OP_SUB;
            3'd2:    dec_op = serial_alu_pkg::OP_AND;
            3'd3:    dec_op = serial_alu_pkg::OP_OR;
            3'd4:    dec_op = serial_alu_pkg::OP_XOR;
            3'd5:    dec_op = serial_alu_pkg::OP_SHL;
            3'd6:    dec_op = serial_alu_pkg::OP_SHR;
            default: dec_op = serial_alu_pkg::OP_ILLEGAL;
        endcase
    end

    // only accept when the buffer is free, otherwise ack waits
    assign capture = (link_state == serial_alu_pkg::LINK_IDLE) && cmd_req && !buf_valid;

    assign cmd_ack = (link_state == serial_alu_pkg::LINK_WAIT_DROP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link_state <= serial_alu_pkg::LINK_IDLE;
            buf_valid  <= 1'b0;
        end else begin
            case (link_state)
                serial_alu_pkg::LINK_IDLE: begin
                    if (capture) begin
                        link_state <= serial_alu_pkg::LINK_WAIT_DROP;
                    end
                end
                serial_alu_pkg::LINK_WAIT_DROP: begin
                    // ack drops only once req is gone
                    if (!cmd_req) begin
                        link_state <= serial_alu_pkg::LINK_IDLE;
                    end
                end
                default: link_state <= serial_alu_pkg::LINK_IDLE;
            endcase

            if (capture) begin
                buf_valid <= 1'b1;
            end else if (buf_take) begin
                buf_valid <= 1'b0;
            end
        end
    end

    // command buffer, direction and carry seed are resolved here
    always_ff @(posedge clk) begin
        if (capture) begin
            buf_op         <= dec_op;
            buf_a          <= cmd_a;
            buf_b          <= cmd_b;
            buf_reverse    <= (dec_op == serial_alu_pkg::OP_SHR);
            buf_carry_init <= (dec_op == serial_alu_pkg::OP_SUB);
        end
    end

endmodule

//--- rtl/nibble_sequencer.sv
// Nibble sequencer
`timescale 1ns/1ps
`include "serial_alu_macros.svh"

module nibble_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     buf_valid,
    input  serial_alu_pkg::alu_op_e  buf_op,
    input  logic [`SALU_WIDTH-1:0]   buf_a,
    input  logic [`SALU_WIDTH-1:0]   buf_b,
    input  logic                     buf_reverse,
    input  logic                     buf_carry_init,
    output logic                     buf_take,
    output serial_alu_pkg::alu_op_e  slice_op,
    output logic [3:0]               slice_a,
    output logic [3:0]               slice_b,
    output logic                     slice_cin,
    input  logic [3:0]               slice_y,
    input  logic                     slice_cout,
    output logic                     done_valid,
    output logic [`SALU_WIDTH-1:0]   done_data,
    output logic                     done_carry,
    output logic                     done_err,
    input  logic                     res_busy
);

    serial_alu_pkg::seq_state_e seq_state;
    serial_alu_pkg::alu_op_e    op_r;
    logic [`SALU_WIDTH-1:0]     a_r;
    logic [`SALU_WIDTH-1:0]     b_r;
    logic [`SALU_WIDTH-1:0]     word_r;
    logic                       rev_r;
    logic                       carry_r;
    logic                       err_r;
    logic [`SALU_IDX_W-1:0]     idx_r;
    logic [`SALU_IDX_W-1:0]     last_idx;

    assign buf_take = (seq_state == serial_alu_pkg::SEQ_IDLE) && buf_valid;

    // walk ends at nibble 0 going down, at the top nibble going up
    assign last_idx = rev_r ? '0 : `SALU_IDX_W'(`SALU_NIBBLES - 1);

    // current nibble to the slice
    assign slice_op  = op_r;
    assign slice_a   = a_r[{idx_r, 2'b00} +: 4];
    assign slice_b   = b_r[{idx_r, 2'b00} +: 4];
    assign slice_cin = carry_r;

    assign done_data  = word_r;
    assign done_carry = carry_r;
    assign done_err   = err_r;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq_state  <= serial_alu_pkg::SEQ_IDLE;
            idx_r      <= '0;
            done_valid <= 1'b0;
        end else begin
            done_valid <= 1'b0;
            case (seq_state)
                serial_alu_pkg::SEQ_IDLE: begin
                    if (buf_take) begin
                        idx_r <= buf_reverse ? `SALU_IDX_W'(`SALU_NIBBLES - 1) : '0;
                        // illegal code has no nibble work
                        if (buf_op == serial_alu_pkg::OP_ILLEGAL) begin
                            seq_state <= serial_alu_pkg::SEQ_DONE;
                        end else begin
                            seq_state <= serial_alu_pkg::SEQ_RUN;
                        end
                    end
                end
                serial_alu_pkg::SEQ_RUN: begin
                    if (idx_r == last_idx) begin
                        seq_state <= serial_alu_pkg::SEQ_DONE;
                    end else if (rev_r) begin
                        idx_r <= idx_r - 1'b1;
                    end else begin
                        idx_r <= idx_r + 1'b1;
                    end
                end
                serial_alu_pkg::SEQ_DONE: begin
                    // hold the word until the result stage is free
                    if (!res_busy) begin
                        done_valid <= 1'b1;
                        seq_state  <= serial_alu_pkg::SEQ_IDLE;
                    end
                end
                default: seq_state <= serial_alu_pkg::SEQ_IDLE;
            endcase
        end
    end

    // working copy of the command and the result being built
    always_ff @(posedge clk) begin
        if (buf_take) begin
            op_r  <= buf_op;
            a_r   <= buf_a;
            b_r   <= buf_b;
            rev_r <= buf_reverse;
            if (buf_op == serial_alu_pkg::OP_ILLEGAL) begin
                word_r  <= '0;
                carry_r <= 1'b0;
                err_r   <= 1'b1;
            end else begin
                carry_r <= buf_carry_init;
                err_r   <= 1'b0;
            end
        end else if (seq_state == serial_alu_pkg::SEQ_RUN) begin
            word_r[{idx_r, 2'b00} +: 4] <= slice_y;
            // slice carry out feeds the next nibble, last one is the final flag
            carry_r <= slice_cout;
        end
    end

endmodule

//--- rtl/result_collect.sv
// Result stage
`timescale 1ns/1ps
`include "serial_alu_macros.svh"

module result_collect (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   done_valid,
    input  logic [`SALU_WIDTH-1:0] done_data,
    input  logic                   done_carry,
    input  logic                   done_err,
    output logic                   res_busy,
    output logic                   res_req,
    output logic [`SALU_WIDTH-1:0] res_data,
    output logic                   res_carry,
    output logic                   res_err,
    input  logic                   res_ack
);

    serial_alu_pkg::link_state_e link_state;
    logic                        capture;

    assign capture = (link_state == serial_alu_pkg::LINK_IDLE) && done_valid;

    // busy until the far side has dropped its ack
    assign res_busy = (link_state != serial_alu_pkg::LINK_IDLE);
    assign res_req  = (link_state == serial_alu_pkg::LINK_REQ);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link_state <= serial_alu_pkg::LINK_IDLE;
        end else begin
            case (link_state)
                serial_alu_pkg::LINK_IDLE: begin
                    if (capture) begin
                        link_state <= serial_alu_pkg::LINK_REQ;
                    end
                end
                serial_alu_pkg::LINK_REQ: begin
                    if (res_ack) begin
                        link_state <= serial_alu_pkg::LINK_WAIT_DROP;
                    end
                end
                serial_alu_pkg::LINK_WAIT_DROP: begin
                    if (!res_ack) begin
                        link_state <= serial_alu_pkg::LINK_IDLE;
                    end
                end
                default: link_state <= serial_alu_pkg::LINK_IDLE;
            endcase
        end
    end

    // held stable for the whole request phase
    always_ff @(posedge clk) begin
        if (capture) begin
            res_data  <= done_data;
            res_carry <= done_carry;
            res_err   <= done_err;
        end
    end

endmodule

//--- rtl/serial_alu_top.sv
// Serial ALU top level
`timescale 1ns/1ps
`include "serial_alu_macros.svh"

module serial_alu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_req,
    input  logic [2:0]             cmd_op,
    input  logic [`SALU_WIDTH-1:0] cmd_a,
    input  logic [`SALU_WIDTH-1:0] cmd_b,
    output logic                   cmd_ack,
    output logic                   res_req,
    output logic [`SALU_WIDTH-1:0] res_data,
    output logic                   res_carry,
    output logic                   res_err,
    input  logic                   res_ack
);

    // decode to execute
    logic                    buf_valid;
    serial_alu_pkg::alu_op_e buf_op;
    logic [`SALU_WIDTH-1:0]  buf_a;
    logic [`SALU_WIDTH-1:0]  buf_b;
    logic                    buf_reverse;
    logic                    buf_carry_init;
    logic                    buf_take;

    // sequencer to slice
    serial_alu_pkg::alu_op_e slice_op;
    logic [3:0]              slice_a;
    logic [3:0]              slice_b;
    logic                    slice_cin;
    logic [3:0]              slice_y;
    logic                    slice_cout;

    // execute to result
    logic                    done_valid;
    logic [`SALU_WIDTH-1:0]  done_data;
    logic                    done_carry;
    logic                    done_err;
    logic                    res_busy;

    op_decode u_op_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_req        (cmd_req),
        .cmd_op         (cmd_op),
        .cmd_a          (cmd_a),
        .cmd_b          (cmd_b),
        .cmd_ack        (cmd_ack),
        .buf_valid      (buf_valid),
        .buf_op         (buf_op),
        .buf_a          (buf_a),
        .buf_b          (buf_b),
        .buf_reverse    (buf_reverse),
        .buf_carry_init (buf_carry_init),
        .buf_take       (buf_take)
    );

    nibble_sequencer u_nibble_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .buf_valid      (buf_valid),
        .buf_op         (buf_op),
        .buf_a          (buf_a),
        .buf_b          (buf_b),
        .buf_reverse    (buf_reverse),
        .buf_carry_init (buf_carry_init),
        .buf_take       (buf_take),
        .slice_op       (slice_op),
        .slice_a        (slice_a),
        .slice_b        (slice_b),
        .slice_cin      (slice_cin),
        .slice_y        (slice_y),
        .slice_cout     (slice_cout),
        .done_valid     (done_valid),
        .done_data      (done_data),
        .done_carry     (done_carry),
        .done_err       (done_err),
        .res_busy       (res_busy)
    );

    nibble_alu u_nibble_alu (
        .op   (slice_op),
        .a    (slice_a),
        .b    (slice_b),
        .cin  (slice_cin),
        .y    (slice_y),
        .cout (slice_cout)
    );

    result_collect u_result_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .done_valid (done_valid),
        .done_data  (done_data),
        .done_carry (done_carry),
        .done_err   (done_err),
        .res_busy   (res_busy),
        .res_req    (res_req),
        .res_data   (res_data),
        .res_carry  (res_carry),
        .res_err    (res_err),
        .res_ack    (res_ack)
    );

endmodule

//--- tb/serial_alu_asserts.sv
// Serial ALU protocol checks
`timescale 1ns/1ps
`include "serial_alu_macros.svh"

module serial_alu_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   cmd_req,
    input logic [2:0]             cmd_op,
    input logic                   cmd_ack,
    input logic                   res_req,
    input logic                   res_ack,
    input logic [`SALU_WIDTH-1:0] res_data,
    input logic                   res_carry,
    input logic                   res_err,
    input logic                   buf_valid,
    input logic                   res_busy
);

    int   fail_count = 0;
    logic rst_seen = 1'b0;
    int   in_flight;
    logic capture;
    logic handshake;

    // same accept condition as the decode stage
    assign capture   = cmd_req && !cmd_ack && !buf_valid;
    assign handshake = res_req && res_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rst_seen <= 1'b1;
        end
    end

    // commands accepted but not yet handed out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(capture) - int'(handshake);
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> $past(cmd_req))
    else begin
        fail_count++;
        $error("cmd_ack rose without cmd_req");
    end

    a_ack_drop_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cmd_ack) |-> $past(!cmd_req))
    else begin
        fail_count++;
        $error("cmd_ack fell while cmd_req was still high");
    end

    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (res_req && !res_ack) |=> (res_req && $stable(res_data)
            && $stable(res_carry) && $stable(res_err)))
    else begin
        fail_count++;
        $error("result request dropped or data changed before res_ack");
    end

    a_reset_quiet: assert property (@(posedge clk)
        (rst_seen && !rst_n) |-> (!res_req && !cmd_ack))
    else begin
        fail_count++;
        $error("res_req or cmd_ack high during reset");
    end

    // an empty pipeline gives the fixed latency, illegal codes skip the nibble walk
    a_min_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (capture && cmd_op != serial_alu_pkg::OP_ILLEGAL && in_flight == 0 && !res_busy)
            |=> (!res_req)[*`SALU_MIN_LAT] ##1 res_req)
    else begin
        fail_count++;
        $error("res_req did not rise exactly at the minimum latency");
    end

endmodule

//--- tb/serial_alu_tb.sv
// Serial ALU testbench
`timescale 1ns/1ps
`include "serial_alu_macros.svh"

module serial_alu_tb;

    localparam int NUM_CMDS       = 40;
    localparam int CYCLES_PER_CMD = 30;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * CYCLES_PER_CMD + RESET_CYCLES;

    logic                   clk;
    logic                   rst_n;
    logic                   cmd_req;
    logic [2:0]             cmd_op;
    logic [`SALU_WIDTH-1:0] cmd_a;
    logic [`SALU_WIDTH-1:0] cmd_b;
    logic                   cmd_ack;
    logic                   res_req;
    logic [`SALU_WIDTH-1:0] res_data;
    logic                   res_carry;
    logic                   res_err;
    logic                   res_ack;

    // expected {err, carry, data} in command order
    logic [`SALU_WIDTH+1:0] exp_q[$];
    int sent          = 0;
    int value_errs    = 0;
    int other_errs    = 0;
    int ack_delay_max = 0;
    int cycle_count   = 0;

    serial_alu_top u_serial_alu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd_op    (cmd_op),
        .cmd_a     (cmd_a),
        .cmd_b     (cmd_b),
        .cmd_ack   (cmd_ack),
        .res_req   (res_req),
        .res_data  (res_data),
        .res_carry (res_carry),
        .res_err   (res_err),
        .res_ack   (res_ack)
    );

    bind serial_alu_top serial_alu_asserts u_serial_alu_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd_op    (cmd_op),
        .cmd_ack   (cmd_ack),
        .res_req   (res_req),
        .res_ack   (res_ack),
        .res_data  (res_data),
        .res_carry (res_carry),
        .res_err   (res_err),
        .buf_valid (buf_valid),
        .res_busy  (res_busy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // word-level model of the slice rules
    function automatic logic [`SALU_WIDTH+1:0] expected_result(input logic [2:0] op,
            input logic [`SALU_WIDTH-1:0] a, input logic [`SALU_WIDTH-1:0] b);
        logic [`SALU_WIDTH:0] wide;
        logic                 err;
        wide = '0;
        err  = 1'b0;
        case (op)
            serial_alu_pkg::OP_ADD: wide = {1'b0, a} + {1'b0, b};
            // carry set means no borrow
            serial_alu_pkg::OP_SUB: wide = {1'b0, a} + {1'b0, ~b} + 1'b1;
            serial_alu_pkg::OP_AND: wide = {1'b0, a & b};
            serial_alu_pkg::OP_OR:  wide = {1'b0, a | b};
            serial_alu_pkg::OP_XOR: wide = {1'b0, a ^ b};
            serial_alu_pkg::OP_SHL: wide = {a, 1'b0};
            serial_alu_pkg::OP_SHR: wide = {a[0], 1'b0, a[`SALU_WIDTH-1:1]};
            default:                err  = 1'b1;
        endcase
        return {err, wide};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic send_cmd(input logic [2:0] op, input logic [`SALU_WIDTH-1:0] a,
            input logic [`SALU_WIDTH-1:0] b);
        exp_q.push_back(expected_result(op, a, b));
        cmd_op  = op;
        cmd_a   = a;
        cmd_b   = b;
        cmd_req = 1'b1;
        next_cycle();
        while (!cmd_ack) begin
            next_cycle();
        end
        cmd_req = 1'b0;
        next_cycle();
        while (cmd_ack) begin
            next_cycle();
        end
        sent++;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || res_ack) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    // one command alone in the pipeline
    task automatic send_isolated(input logic [2:0] op, input logic [`SALU_WIDTH-1:0] a,
            input logic [`SALU_WIDTH-1:0] b);
        send_cmd(op, a, b);
        wait_drain();
    endtask

    task automatic check_result();
        logic [`SALU_WIDTH+1:0] exp;
        if (exp_q.size() == 0) begin
            $display("Error at %0t: a result arrived with no command outstanding", $time);
            other_errs++;
        end else begin
            exp = exp_q.pop_front();
            assert (res_data === exp[`SALU_WIDTH-1:0]) else begin
                $display("Fail at %0t: res_data got %h expected %h",
                    $time, res_data, exp[`SALU_WIDTH-1:0]);
                value_errs++;
            end
            assert (res_carry === exp[`SALU_WIDTH]) else begin
                $display("Fail at %0t: res_carry got %b expected %b",
                    $time, res_carry, exp[`SALU_WIDTH]);
                value_errs++;
            end
            assert (res_err === exp[`SALU_WIDTH+1]) else begin
                $display("Fail at %0t: res_err got %b expected %b",
                    $time, res_err, exp[`SALU_WIDTH+1]);
                value_errs++;
            end
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d commands, %0d value errors, %0d other errors, %0d assert fails",
            sent, value_errs, other_errs, u_serial_alu_top.u_serial_alu_asserts.fail_count);
    endtask

    // result side with optional random ack delay
    initial begin : result_side
        int delay;
        forever begin
            next_cycle();
            if (res_req === 1'b1 && !res_ack) begin
                delay = $urandom_range(ack_delay_max, 0);
                repeat (delay) next_cycle();
                check_result();
                res_ack = 1'b1;
                while (res_req) begin
                    next_cycle();
                end
                res_ack = 1'b0;
            end
        end
    end

    initial begin : main_seq
        void'($urandom(32'h6779e7c2));
        rst_n   = 1'b0;
        cmd_req = 1'b0;
        cmd_op  = 3'd0;
        cmd_a   = '0;
        cmd_b   = '0;
        res_ack = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();

        // carries across nibble boundaries
        send_isolated(serial_alu_pkg::OP_ADD, 32'hefffffff, 32'h00000001);
        send_isolated(serial_alu_pkg::OP_ADD, 32'hffff0fff, 32'h00000002);
        send_isolated(serial_alu_pkg::OP_SUB, 32'h00001234, 32'h00005000);
        send_isolated(serial_alu_pkg::OP_SUB, 32'h00005000, 32'h00001234);
        send_isolated(serial_alu_pkg::OP_SUB, 32'h9abcdef0, 32'h9abcdef0);

        send_isolated(serial_alu_pkg::OP_SHR, 32'h06000000, 32'h0);
        send_isolated(serial_alu_pkg::OP_SHL, 32'h80000001, 32'h0);
        send_isolated(serial_alu_pkg::OP_AND, $urandom, $urandom);
        send_isolated(serial_alu_pkg::OP_OR, $urandom, $urandom);
        send_isolated(serial_alu_pkg::OP_XOR, $urandom, $urandom);

        // illegal code, then a normal command behind it
        send_isolated(serial_alu_pkg::OP_ILLEGAL, $urandom, $urandom);
        send_isolated(serial_alu_pkg::OP_SUB, 32'h00000010, 32'h00000003);

        // back to back, long ack delays stall the sequencer in its done state
        ack_delay_max = 12;
        while (sent < NUM_CMDS) begin
            send_cmd(3'($urandom_range(7, 0)), $urandom, $urandom);
        end
        wait_drain();

        print_summary();
        if (value_errs + other_errs + u_serial_alu_top.u_serial_alu_asserts.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout: run not finished after %0d cycles, %0d results still pending",
            TIMEOUT_CYCLES, exp_q.size());
        print_summary();
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/serial_alu_pkg.sv
rtl/nibble_alu.sv
rtl/op_decode.sv
rtl/nibble_sequencer.sv
rtl/result_collect.sv
rtl/serial_alu_top.sv
tb/serial_alu_asserts.sv
tb/serial_alu_tb.sv
